//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   // address split: tag | index | word select | byte
   localparam int TAG_W = 26;
   localparam int IDX_W = 3;
   localparam int OFS_W = 1;

   localparam int NUM_SETS = 8; // default set count

   typedef logic [31:0]      word_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [IDX_W-1:0] idx_t;

   // request from the datapath, held until dhit
   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } dp_req_t;

   // request toward memory, one word per transfer
   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   // lookup result of one way
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;   // stored tag, used to rebuild write-back address
      word_t data;  // word picked by word_sel
   } way_status_t;

   // update command into one way, applied at the clock edge
   typedef struct packed {
      logic  we;        // word write
      logic  sel;       // which word of the block
      word_t data;
      idx_t  idx;
      tag_t  tag;
      logic  fill;      // block now valid with this tag
      logic  set_dirty;
      logic  clr_dirty;
   } way_wr_t;

endpackage

`default_nettype wire

//--- design/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way
   import dcache_pkg::*;
#(
   parameter int SETS = NUM_SETS
)
(
   input  logic        CLK,
   input  logic        nRST,
   input  idx_t        lookup_idx,
   input  tag_t        lookup_tag,
   input  logic        word_sel,
   input  way_wr_t     wr,
   output way_status_t status
);

   // per-entry state
   logic [SETS-1:0] valid;
   logic [SETS-1:0] dirty;
   tag_t            tags [SETS];
   word_t           data [SETS][2];

   logic  entry_valid;
   logic  entry_dirty;
   tag_t  entry_tag;
   word_t entry_word;

   // combinational lookup on the shared index
   always_comb
   begin
      entry_valid = valid[lookup_idx];
      entry_dirty = dirty[lookup_idx];
      entry_tag   = tags[lookup_idx];
      entry_word  = data[lookup_idx][word_sel];
   end

   always_comb
   begin
      status.hit   = entry_valid && (entry_tag == lookup_tag);
      status.valid = entry_valid;
      status.dirty = entry_dirty;
      status.tag   = entry_tag;
      status.data  = entry_word;
   end

   // control bits, cleared on reset
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else
      begin
         if (wr.fill)
            valid[wr.idx] <= 1'b1;

         // set wins if both are asked for in one cycle
         if (wr.set_dirty)
         begin
            dirty[wr.idx] <= 1'b1;
         end
         else if (wr.clr_dirty)
         begin
            dirty[wr.idx] <= 1'b0;
         end
      end
   end

   // tag and data storage
   always_ff @(posedge CLK)
   begin
      if (wr.fill)
         tags[wr.idx] <= wr.tag;

      if (wr.we)
         data[wr.idx][wr.sel] <= wr.data; // hit store or fetched word
   end

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
   import dcache_pkg::*;
#(
   parameter int SETS = NUM_SETS
)
(
   input  logic        CLK,
   input  logic        nRST,
   input  dp_req_t     req,
   input  logic        halt,
   input  way_status_t status0,
   input  way_status_t status1,
   input  word_t       dload,
   input  logic        dwait,
   output logic        dhit,
   output logic        flushed,
   output word_t       dmemload,
   output idx_t        lookup_idx,
   output tag_t        lookup_tag,
   output logic        word_sel,
   output way_wr_t     wr0,
   output way_wr_t     wr1,
   output mem_req_t    mem
);

   typedef enum logic [3:0] {
      IDLE,
      WB0,
      WB1,
      FETCH0,
      FETCH1,
      FLUSH_SCAN,
      FLUSH_WB0,
      FLUSH_WB1,
      FLUSH_DONE
   } state_t;

   state_t state, next_state;

   // request address fields
   tag_t req_tag;
   idx_t req_idx;
   logic req_act;

   logic [SETS-1:0] lru; // points at the way to evict next
   logic            hit;
   logic            hit_way;

   logic            flush_mode;
   idx_t            flush_set;
   logic            flush_way;
   logic            flush_last;
   logic            flush_step;

   logic            sel_way;    // victim on a miss, scan way during flush
   way_status_t     sel_status;
   logic            sel_dirty;

   way_wr_t         wr_cmd;
   logic            wr_way;

   always_comb
   begin
      req_tag = req.addr[31 -: TAG_W];
      req_idx = req.addr[2+OFS_W +: IDX_W];
      req_act = req.ren || req.wen;
   end

   assign hit     = status0.hit || status1.hit;
   assign hit_way = status1.hit;

   assign flush_mode = (state == FLUSH_SCAN) || (state == FLUSH_WB0) ||
                       (state == FLUSH_WB1) || (state == FLUSH_DONE);
   assign flush_last = (flush_set == idx_t'(SETS-1)) && flush_way;

   assign lookup_idx = flush_mode ? flush_set : req_idx;
   assign lookup_tag = req_tag;

   // block words go out in order 0 then 1
   always_comb
   begin
      case (state)
         WB0, FETCH0, FLUSH_WB0: word_sel = 1'b0;
         WB1, FETCH1, FLUSH_WB1: word_sel = 1'b1;
         default:                word_sel = req.addr[2];
      endcase
   end

   assign sel_way    = flush_mode ? flush_way : lru[req_idx];
   assign sel_status = sel_way ? status1 : status0;
   assign sel_dirty  = sel_status.valid && sel_status.dirty;

   // datapath side, hits only answered from idle
   assign dhit     = (state == IDLE) && req_act && hit;
   assign dmemload = hit_way ? status1.data : status0.data;
   assign flushed  = (state == FLUSH_DONE);

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (halt)
               next_state = FLUSH_SCAN;
            else if (req_act && !hit)
               next_state = sel_dirty ? WB0 : FETCH0;
         end
         WB0:
            if (!dwait) next_state = WB1;
         WB1:
            if (!dwait) next_state = FETCH0;
         FETCH0:
            if (!dwait) next_state = FETCH1;
         FETCH1:
            if (!dwait) next_state = IDLE; // held request hits next cycle
         FLUSH_SCAN:
         begin
            if (sel_dirty)
               next_state = FLUSH_WB0;
            else if (flush_last)
               next_state = FLUSH_DONE;
         end
         FLUSH_WB0:
            if (!dwait) next_state = FLUSH_WB1;
         FLUSH_WB1:
         begin
            if (!dwait)
               next_state = flush_last ? FLUSH_DONE : FLUSH_SCAN;
         end
         FLUSH_DONE:
            next_state = FLUSH_DONE;
         default:
            next_state = IDLE;
      endcase
   end

   // memory port, request held steady while dwait is high
   always_comb
   begin
      mem = '0;
      case (state)
         WB0, WB1, FLUSH_WB0, FLUSH_WB1:
         begin
            mem.wen   = 1'b1;
            mem.addr  = {sel_status.tag, lookup_idx, word_sel, 2'b00};
            mem.store = sel_status.data;
         end
         FETCH0, FETCH1:
         begin
            mem.ren  = 1'b1;
            mem.addr = {req_tag, req_idx, word_sel, 2'b00};
         end
         default: ;
      endcase
   end

   // one update command, steered to a single way
   always_comb
   begin
      wr_cmd     = '0;
      wr_cmd.idx = lookup_idx;
      wr_cmd.tag = req_tag;
      wr_cmd.sel = word_sel;
      wr_way     = sel_way;
      case (state)
         IDLE:
         begin
            if (dhit && req.wen)
            begin
               wr_cmd.we        = 1'b1;
               wr_cmd.data      = req.store;
               wr_cmd.set_dirty = 1'b1;
               wr_way           = hit_way;
            end
         end
         FETCH0:
         begin
            wr_cmd.we   = !dwait;
            wr_cmd.data = dload;
         end
         FETCH1:
         begin
            wr_cmd.we        = !dwait;
            wr_cmd.data      = dload;
            wr_cmd.fill      = !dwait;
            wr_cmd.clr_dirty = !dwait; // fresh block is clean
         end
         FLUSH_WB1:
            wr_cmd.clr_dirty = !dwait;
         default: ;
      endcase
      wr0 = wr_way ? way_wr_t'('0) : wr_cmd;
      wr1 = wr_way ? wr_cmd : way_wr_t'('0);
   end

   // move on after a clean entry or a finished write-back
   assign flush_step = ((state == FLUSH_SCAN) && !sel_dirty) ||
                       ((state == FLUSH_WB1) && !dwait);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         lru       <= '0;
         flush_set <= '0;
         flush_way <= 1'b0;
      end
      else
      begin
         state <= next_state;

         if (dhit)
            lru[req_idx] <= ~hit_way; // other way becomes the victim
         else if ((state == FETCH1) && !dwait)
            lru[req_idx] <= ~sel_way;

         if (flush_step)
            {flush_set, flush_way} <= {flush_set, flush_way} + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
   import dcache_pkg::*;
#(
   parameter int SETS = NUM_SETS
)
(
   input  logic     CLK,
   input  logic     nRST,
   input  dp_req_t  req,
   input  logic     halt,
   input  word_t    dload,
   input  logic     dwait,
   output logic     dhit,
   output logic     flushed,
   output word_t    dmemload,
   output mem_req_t mem
);

   // shared lookup, driven by the controller
   idx_t lookup_idx;
   tag_t lookup_tag;
   logic word_sel;

   way_status_t status0;
   way_status_t status1;
   way_wr_t     wr0;
   way_wr_t     wr1;

   dcache_way #(.SETS(SETS)) way0_inst (
      .CLK        (CLK),
      .nRST       (nRST),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .word_sel   (word_sel),
      .wr         (wr0),
      .status     (status0)
   );

   dcache_way #(.SETS(SETS)) way1_inst (
      .CLK        (CLK),
      .nRST       (nRST),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .word_sel   (word_sel),
      .wr         (wr1),
      .status     (status1)
   );

   dcache_ctrl #(.SETS(SETS)) ctrl_inst (
      .CLK        (CLK),
      .nRST       (nRST),
      .req        (req),
      .halt       (halt),
      .status0    (status0),
      .status1    (status1),
      .dload      (dload),
      .dwait      (dwait),
      .dhit       (dhit),
      .flushed    (flushed),
      .dmemload   (dmemload),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .word_sel   (word_sel),
      .wr0        (wr0),
      .wr1        (wr1),
      .mem        (mem)
   );

endmodule

`default_nettype wire

//--- tests/dcache_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_clk_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 5
)
(
   output logic CLK,
   output logic nRST
);

   initial
   begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   // release on a falling edge, away from the sampling edge
   initial
   begin
      nRST = 1'b0;
      repeat (RST_CYCLES) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
   end

endmodule

`default_nettype wire

//--- tests/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker
   import dcache_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input logic     dhit,
   input logic     flushed,
   input logic     dwait,
   input mem_req_t mem
);

   // one direction per transfer
   assert property (@(posedge CLK) disable iff (!nRST) !(mem.ren && mem.wen))
      else $error("memory read and write requested together");

   // no answer to the datapath while the memory port is busy
   assert property (@(posedge CLK) disable iff (!nRST) !(dhit && (mem.ren || mem.wen)))
      else $error("dhit raised during a memory access");

   assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
      else $error("flushed dropped before reset");

   assert property (@(posedge CLK) disable iff (!nRST)
                    (mem.ren || mem.wen) && dwait |=> $stable(mem.addr))
      else $error("memory address changed while dwait was high");

endmodule

bind dcache_top dcache_checker checker_inst (
   .CLK     (CLK),
   .nRST    (nRST),
   .dhit    (dhit),
   .flushed (flushed),
   .dwait   (dwait),
   .mem     (mem)
);

`default_nettype wire

//--- tests/dcache_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_monitor
   import dcache_pkg::*;
#(
   parameter word_t PAT = 32'hA5A5_0000
)
(
   input  logic     CLK,
   input  dp_req_t  req,
   input  logic     dhit,
   input  word_t    dmemload,
   input  mem_req_t mem,
   input  logic     dwait,
   input  logic     flushed,
   input  int       test_num,
   input  word_t    exp_load,
   input  int       exp_rd,
   input  int       exp_wr,
   input  word_t    wb_addr,
   input  logic     test_end,
   input  logic     timed_out,
   input  logic     summary,
   output int       fail_count
);

   int    rd_cnt     = 0;
   int    wr_cnt     = 0;
   int    pass_count = 0;
   int    fails      = 0;
   word_t first_wr   = '0;
   word_t prev_wr    = '0;
   logic  load_bad   = 1'b0;
   logic  wb_bad     = 1'b0;
   word_t shadow [word_t];  // stores accepted from the datapath
   word_t written [word_t]; // words seen going out on the memory port

   assign fail_count = fails;

   // stored words that never reached memory with the right value
   function automatic int missing_words();
      int n;
      n = 0;
      foreach (shadow[a])
         if (!written.exists(a) || written[a] !== shadow[a])
            n++;
      return n;
   endfunction

   // latest store if any, else the untouched memory pattern
   function automatic word_t expected_word(input word_t addr);
      if (shadow.exists(addr))
         return shadow[addr];
      return addr ^ PAT;
   endfunction

   always @(posedge CLK)
   begin
      int   bad_words;
      logic ok;
      if (dhit && req.ren && dmemload !== exp_load)
      begin
         $display("ERR %0t: test %0d read of %h returned %h, expected %h",
                  $time, test_num, req.addr, dmemload, exp_load);
         load_bad = 1'b1;
      end
      if (dhit && req.wen)
         shadow[req.addr] = req.store;
      if (mem.ren && !dwait)
         rd_cnt++;
      if (mem.wen && !dwait)
      begin
         if (wr_cnt == 0)
            first_wr = mem.addr; // start of the written-back block
         // word 0 then word 1 of one block
         if (mem.addr[2] !== wr_cnt[0] ||
             (wr_cnt[0] && mem.addr !== prev_wr + 32'd4) ||
             mem.store !== expected_word(mem.addr))
         begin
            $display("ERR %0t: test %0d wrote %h to %h, not the expected block word",
                     $time, test_num, mem.store, mem.addr);
            wb_bad = 1'b1;
         end
         prev_wr = mem.addr;
         wr_cnt++;
         written[mem.addr] = mem.store;
      end

      if (test_end)
      begin
         bad_words = flushed ? missing_words() : 0;
         ok        = 1'b0;
         if (timed_out)
            $display("test %0d failed: the cache never answered in time", test_num);
         else if (rd_cnt != exp_rd || wr_cnt != exp_wr)
            $display("ERR %0t: test %0d made %0d reads and %0d writes, expected %0d and %0d",
                     $time, test_num, rd_cnt, wr_cnt, exp_rd, exp_wr);
         else if (exp_wr != 0 && first_wr !== wb_addr)
            $display("ERR %0t: test %0d wrote back from %h, expected %h",
                     $time, test_num, first_wr, wb_addr);
         else if (wb_bad)
            $display("test %0d failed on its written-back words", test_num);
         else if (bad_words != 0)
            $display("ERR %0t: test %0d found %0d stored words missing in memory",
                     $time, test_num, bad_words);
         else if (load_bad)
            $display("test %0d failed on its load value", test_num);
         else
         begin
            ok = 1'b1;
            $display("test %0d passed", test_num);
         end
         if (ok)
            pass_count++;
         else
            fails++;
         rd_cnt   = 0;
         wr_cnt   = 0;
         load_bad = 1'b0;
         wb_bad   = 1'b0;
      end

      if (summary)
         $display("%0d tests passed, %0d failed", pass_count, fails);
   end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
   import dcache_pkg::*;
();

   localparam word_t PAT       = 32'hA5A5_0000; // unwritten memory reads addr ^ PAT
   localparam int    NUM_TESTS = 10;
   localparam int    TIMEOUT   = 100;

   typedef struct packed {
      logic  wr;
      word_t addr;
      word_t store;
      word_t exp_load;
      int    exp_rd;   // memory reads during the test
      int    exp_wr;   // memory writes during the test
      word_t wb_addr;  // first write-back address
   } test_t;

   // set 1 and set 2 end up holding one dirty block each
   localparam test_t FLUSH_EXP = '{1'b0, 32'h0, 32'h0, 32'h0, 0, 4, 32'h0000_0188};

   logic     CLK;
   logic     nRST;
   dp_req_t  req;
   logic     halt;
   word_t    dload = '0;
   logic     dwait = 1'b0;
   logic     dhit;
   logic     flushed;
   word_t    dmemload;
   mem_req_t mem;

   test_t tests [NUM_TESTS];
   test_t cur_t;
   int    cur_num;
   logic  test_end;
   logic  timed_out;
   logic  summary;
   logic  aborted;
   int    fail_count;
   logic  dhit_q = 1'b0;

   word_t mem_words [word_t];
   int    seed      = 32'h49ed;
   int    wait_left = 0;
   logic  busy      = 1'b0;

   dcache_clk_gen #(.PERIOD(20), .RST_CYCLES(5)) clk_gen_inst (
      .CLK  (CLK),
      .nRST (nRST)
   );

   dcache_top #(.SETS(NUM_SETS)) dcache_top_inst (
      .CLK      (CLK),
      .nRST     (nRST),
      .req      (req),
      .halt     (halt),
      .dload    (dload),
      .dwait    (dwait),
      .dhit     (dhit),
      .flushed  (flushed),
      .dmemload (dmemload),
      .mem      (mem)
   );

   dcache_monitor #(.PAT(PAT)) monitor_inst (
      .CLK        (CLK),
      .req        (req),
      .dhit       (dhit),
      .dmemload   (dmemload),
      .mem        (mem),
      .dwait      (dwait),
      .flushed    (flushed),
      .test_num   (cur_num),
      .exp_load   (cur_t.exp_load),
      .exp_rd     (cur_t.exp_rd),
      .exp_wr     (cur_t.exp_wr),
      .wb_addr    (cur_t.wb_addr),
      .test_end   (test_end),
      .timed_out  (timed_out),
      .summary    (summary),
      .fail_count (fail_count)
   );

   always @(posedge CLK)
      dhit_q <= dhit; // hit taken at this edge

   function automatic word_t mem_read(input word_t addr);
      if (mem_words.exists(addr))
         return mem_words[addr];
      return addr ^ PAT;
   endfunction

   // memory responder, 0 to 3 wait cycles per word
   always @(negedge CLK)
   begin
      if (mem.ren || mem.wen)
      begin
         if (!busy)
         begin
            busy      = 1'b1;
            wait_left = $unsigned($random(seed)) % 4;
         end
         if (wait_left == 0)
         begin
            dwait = 1'b0;
            busy  = 1'b0;
            if (mem.ren)
               dload = mem_read(mem.addr);
            else
               mem_words[mem.addr] = mem.store; // transfer lands at the next edge
         end
         else
         begin
            dwait     = 1'b1;
            wait_left = wait_left - 1;
         end
      end
      else
         dwait = 1'b0;
   end

   // tags 4..7 share set 1, tags 8 and 9 share set 2
   task automatic load_tests();
      tests[0] = '{1'b0, 32'h0000_0108, 32'h0, 32'h0000_0108 ^ PAT, 2, 0, 32'h0};
      tests[1] = '{1'b0, 32'h0000_010C, 32'h0, 32'h0000_010C ^ PAT, 0, 0, 32'h0};
      tests[2] = '{1'b1, 32'h0000_0108, 32'h1111_0001, 32'h0, 0, 0, 32'h0};
      tests[3] = '{1'b0, 32'h0000_0108, 32'h0, 32'h1111_0001, 0, 0, 32'h0};
      tests[4] = '{1'b1, 32'h0000_0148, 32'h2222_0005, 32'h0, 2, 0, 32'h0};
      tests[5] = '{1'b1, 32'h0000_0188, 32'h3333_0006, 32'h0, 2, 2, 32'h0000_0108};
      tests[6] = '{1'b0, 32'h0000_01C8, 32'h0, 32'h0000_01C8 ^ PAT, 2, 2, 32'h0000_0148};
      tests[7] = '{1'b0, 32'h0000_0210, 32'h0, 32'h0000_0210 ^ PAT, 2, 0, 32'h0};
      tests[8] = '{1'b1, 32'h0000_0254, 32'h4444_0009, 32'h0, 2, 0, 32'h0};
      tests[9] = '{1'b0, 32'h0000_0254, 32'h0, 32'h4444_0009, 0, 0, 32'h0};
   endtask

   // one idle cycle between requests carries the end-of-test strobe
   task automatic close_test(input logic hung);
      timed_out = hung;
      aborted   = aborted || hung;
      test_end  = 1'b1;
      @(negedge CLK);
      test_end  = 1'b0;
      timed_out = 1'b0;
   endtask

   task automatic apply_request(input test_t t, input int num);
      int cnt;
      cur_t     = t;
      cur_num   = num;
      req.ren   = !t.wr;
      req.wen   = t.wr;
      req.addr  = t.addr;
      req.store = t.store;
      cnt = 0;
      do
      begin
         @(negedge CLK);
         cnt++;
      end
      while (!dhit_q && cnt < TIMEOUT);
      req = '0;
      close_test(!dhit_q);
   endtask

   task automatic flush_and_wait(input test_t t, input int num);
      int cnt;
      cur_t   = t;
      cur_num = num;
      halt    = 1'b1;
      cnt = 0;
      while (!flushed && cnt < TIMEOUT)
      begin
         @(negedge CLK);
         cnt++;
      end
      close_test(!flushed);
   endtask

   initial
   begin
      int cnt;
      req       = '0;
      halt      = 1'b0;
      cur_t     = '0;
      cur_num   = 0;
      test_end  = 1'b0;
      timed_out = 1'b0;
      summary   = 1'b0;
      aborted   = 1'b0;
      load_tests();

      cnt = 0;
      while (nRST !== 1'b1 && cnt < TIMEOUT)
      begin
         @(negedge CLK);
         cnt++;
      end
      if (nRST !== 1'b1)
      begin
         $display("reset was never released");
         aborted = 1'b1;
      end

      for (int i = 0; i < NUM_TESTS && !aborted; i++)
         apply_request(tests[i], i + 1);
      if (!aborted)
         flush_and_wait(FLUSH_EXP, NUM_TESTS + 1);

      summary = 1'b1;
      @(negedge CLK);
      summary = 1'b0;
      if (!aborted && fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/dcache_clk_gen.sv
tests/dcache_checker.sv
tests/dcache_monitor.sv
tests/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dcache_tb -f sim.f -o dcache_sim

out=$(./obj_dir/dcache_sim) || { echo "$out"; exit 1; }
echo "$out"

if grep -q 'All tests passed!' <<< "$out"; then
   exit 0
fi
exit 1
